// File: rtl/matrix_divider_pkg.sv
/*
  Shared widths, saturation limits and packed structs for the matrix
  element-wise Q16.16 divider. Every block imports this package in its
  module header.
*/

package matrix_divider_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Widths and constants
  ////////////////////////////////////////////////////////////////////////////

  // Signed Q16.16 element
  localparam int DATA_W = 32;
  localparam int FRAC_W = 16;

  // Matrix dimension counters
  localparam int SIZE_W = 8;

  // One restoring step per quotient bit
  localparam int DIV_CYCLES = DATA_W + FRAC_W;

  // Saturation limits in Q16.16
  localparam logic [DATA_W-1:0] SAT_POS = 32'h7fff_ffff;
  localparam logic [DATA_W-1:0] SAT_NEG = 32'h8000_0000;

  ////////////////////////////////////////////////////////////////////////////
  // Structs
  ////////////////////////////////////////////////////////////////////////////

  // Position flags riding along with each element
  typedef struct packed {
    logic row_end;
    logic last;
  } elem_tag_t;

  // Operand pair handed to the divider
  typedef struct packed {
    logic [DATA_W-1:0] a;
    logic [DATA_W-1:0] b;
    elem_tag_t         tag;
  } div_operands_t;

  // Raw unsigned quotient plus status for the result stage
  typedef struct packed {
    logic [DATA_W-1:0] quotient;
    logic              overflow;
    logic              div_zero;
    logic              sign;
    elem_tag_t         tag;
  } div_result_t;

endpackage

// File: rtl/matrix_index_sequencer.sv
/*
  Tracks the I/J position of the next element to be issued and owns the
  busy window of a matrix operation. Sizes are sampled on start; the tag
  of the current element is offered to operand capture.
*/

`timescale 1ns/10ps

module matrix_index_sequencer
  import matrix_divider_pkg::*;
(
  input  logic              CLK,
  input  logic              RST,
  input  logic              start,
  input  logic [SIZE_W-1:0] size_i,
  input  logic [SIZE_W-1:0] size_j,
  input  logic              issue,
  input  logic              out_last,
  output logic              accept_en,
  output elem_tag_t         tag,
  output logic              busy
);

  // Sampled dimensions
  logic [SIZE_W-1:0] size_i_q;
  logic [SIZE_W-1:0] size_j_q;

  // Index of the next element to issue
  logic [SIZE_W-1:0] idx_i;
  logic [SIZE_W-1:0] idx_j;

  // Set once the final element has left capture
  logic issued_all;

  logic start_take;

  // Start only counts when idle
  assign start_take = start && !busy;

  ////////////////////////////////////////////////////////////////////////////
  // Tag decode
  ////////////////////////////////////////////////////////////////////////////

  assign tag.row_end = (idx_j == size_j_q - SIZE_W'(1));
  assign tag.last    = tag.row_end && (idx_i == size_i_q - SIZE_W'(1));

  // Operands still wanted
  assign accept_en = busy && !issued_all;

  ////////////////////////////////////////////////////////////////////////////
  // Index counters and busy window
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      busy       <= 1'b0;
      issued_all <= 1'b0;
      size_i_q   <= '0;
      size_j_q   <= '0;
      idx_i      <= '0;
      idx_j      <= '0;
    end else if (start_take) begin
      busy       <= 1'b1;
      issued_all <= 1'b0;
      size_i_q   <= size_i;
      size_j_q   <= size_j;
      idx_i      <= '0;
      idx_j      <= '0;
    end else if (busy) begin
      if (issue) begin
        if (tag.last) begin
          issued_all <= 1'b1;
        end else if (tag.row_end) begin
          // Wrap to next row
          idx_i <= idx_i + SIZE_W'(1);
          idx_j <= '0;
        end else begin
          idx_j <= idx_j + SIZE_W'(1);
        end
      end
      // Final element has left the result stage
      if (out_last) begin
        busy <= 1'b0;
      end
    end
  end

  // Zero-sized matrix would never produce a last element
  a_start_size : assert property (@(posedge CLK) disable iff (RST)
    start_take |-> (size_i != '0) && (size_j != '0));

  // Capture only launches while elements remain
  a_issue_window : assert property (@(posedge CLK) disable iff (RST)
    issue |-> accept_en);

endmodule

// File: rtl/operand_capture.sv
/*
  Pairs the A and B operand streams. Each operand has a one-entry slot so
  the two may arrive in any order; a full pair is issued to the divider
  as soon as the divider is idle.
*/

`timescale 1ns/10ps

module operand_capture
  import matrix_divider_pkg::*;
(
  input  logic              CLK,
  input  logic              RST,
  input  logic              accept_en,
  input  elem_tag_t         tag,
  input  logic              a_valid,
  input  logic [DATA_W-1:0] a_data,
  output logic              a_ready,
  input  logic              b_valid,
  input  logic [DATA_W-1:0] b_data,
  output logic              b_ready,
  input  logic              div_busy,
  output logic              issue,
  output div_operands_t     operands
);

  // Slot state
  logic a_full;
  logic b_full;

  // Slot payload
  logic [DATA_W-1:0] a_q;
  logic [DATA_W-1:0] b_q;

  // Ready only into an empty slot
  assign a_ready = accept_en && !a_full;
  assign b_ready = accept_en && !b_full;

  // Launch when pair complete and divider free
  assign issue = a_full && b_full && !div_busy;

  // Tag comes from the sequencer at launch time
  assign operands.a   = a_q;
  assign operands.b   = b_q;
  assign operands.tag = tag;

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      a_full <= 1'b0;
      b_full <= 1'b0;
    end else begin
      if (a_valid && a_ready) begin
        a_full <= 1'b1;
      end else if (issue) begin
        a_full <= 1'b0;
      end
      if (b_valid && b_ready) begin
        b_full <= 1'b1;
      end else if (issue) begin
        b_full <= 1'b0;
      end
    end
  end

  always_ff @(posedge CLK) begin
    if (a_valid && a_ready) begin
      a_q <= a_data;
    end
    if (b_valid && b_ready) begin
      b_q <= b_data;
    end
  end

  // Divider must take the pair on the next edge
  a_issue_taken : assert property (@(posedge CLK) disable iff (RST)
    issue |=> div_busy);

endmodule

// File: rtl/fixed_divider.sv
/*
  Iterative restoring divider for signed Q16.16 operands. Works on
  magnitudes with the dividend pre-shifted by FRAC_W, one quotient bit
  per cycle. Sign, divide-by-zero and overflow travel to the result stage.
*/

`timescale 1ns/10ps

module fixed_divider
  import matrix_divider_pkg::*;
(
  input  logic          CLK,
  input  logic          RST,
  input  logic          issue,
  input  div_operands_t operands,
  output logic          div_busy,
  output logic          res_valid,
  output div_result_t   result
);

  localparam int CNT_W = $clog2(DIV_CYCLES + 1);
  localparam int QUO_W = DATA_W + FRAC_W;

  // Operand magnitudes
  logic [DATA_W-1:0] a_mag;
  logic [DATA_W-1:0] b_mag;

  // Steps left
  logic [CNT_W-1:0] count;

  // Dividend bits leave at the top, quotient bits enter at the bottom
  logic [QUO_W-1:0]  quo_q;
  logic [DATA_W-1:0] rem_q;
  logic [DATA_W-1:0] div_q;

  // Status held for the whole operation
  logic      sign_q;
  logic      zero_q;
  elem_tag_t tag_q;

  // One restoring step
  logic [DATA_W:0]   rem_shift;
  logic [DATA_W+1:0] diff;
  logic              step_ok;
  logic [DATA_W-1:0] rem_next;
  logic [QUO_W-1:0]  quo_next;
  logic              final_step;

  // Two's complement magnitude; 0x8000_0000 maps onto itself as unsigned
  assign a_mag = operands.a[DATA_W-1] ? DATA_W'(-operands.a) : operands.a;
  assign b_mag = operands.b[DATA_W-1] ? DATA_W'(-operands.b) : operands.b;

  ////////////////////////////////////////////////////////////////////////////
  // Restoring step
  ////////////////////////////////////////////////////////////////////////////

  assign rem_shift = {rem_q, quo_q[QUO_W-1]};
  assign diff      = {1'b0, rem_shift} - {2'b00, div_q};

  // No borrow means divisor fits
  assign step_ok  = !diff[DATA_W+1];
  assign rem_next = step_ok ? diff[DATA_W-1:0] : rem_shift[DATA_W-1:0];
  assign quo_next = {quo_q[QUO_W-2:0], step_ok};

  assign final_step = div_busy && (count == CNT_W'(1));

  ////////////////////////////////////////////////////////////////////////////
  // Control
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      div_busy  <= 1'b0;
      res_valid <= 1'b0;
      count     <= '0;
    end else begin
      res_valid <= final_step;
      if (issue) begin
        div_busy <= 1'b1;
        count    <= CNT_W'(DIV_CYCLES);
      end else if (div_busy) begin
        count <= count - CNT_W'(1);
        if (final_step) begin
          div_busy <= 1'b0;
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Datapath
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK) begin
    if (issue) begin
      quo_q  <= {a_mag, FRAC_W'(0)};
      rem_q  <= '0;
      div_q  <= b_mag;
      // 0/0 has both sign bits clear and saturates positive
      sign_q <= operands.a[DATA_W-1] ^ operands.b[DATA_W-1];
      zero_q <= (operands.b == '0);
      tag_q  <= operands.tag;
    end else if (div_busy) begin
      quo_q <= quo_next;
      rem_q <= rem_next;
    end
    // Result register survives while the next pair runs
    if (final_step) begin
      result.quotient <= quo_next[DATA_W-1:0];
      result.overflow <= |quo_next[QUO_W-1:DATA_W-1];
      result.div_zero <= zero_q;
      result.sign     <= sign_q;
      result.tag      <= tag_q;
    end
  end

endmodule

// File: rtl/division_result_stage.sv
/*
  Output register of the divider. Applies the sign to the raw quotient,
  saturates on overflow or divide-by-zero and drives the output stream
  with its row-end and last flags.
*/

`timescale 1ns/10ps

module division_result_stage
  import matrix_divider_pkg::*;
(
  input  logic              CLK,
  input  logic              RST,
  input  logic              res_valid,
  input  div_result_t       result,
  output logic              out_valid,
  output logic [DATA_W-1:0] out_data,
  output logic              out_row_end,
  output logic              out_last
);

  logic [DATA_W-1:0] signed_q;
  logic [DATA_W-1:0] final_q;

  // Negate magnitude for negative results
  assign signed_q = result.sign ? DATA_W'(-result.quotient) : result.quotient;

  // Clamp toward the sign of the true quotient
  always_comb begin
    if (result.div_zero || result.overflow) begin
      final_q = result.sign ? SAT_NEG : SAT_POS;
    end else begin
      final_q = signed_q;
    end
  end

  // Flags
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      out_valid   <= 1'b0;
      out_row_end <= 1'b0;
      out_last    <= 1'b0;
    end else begin
      out_valid   <= res_valid;
      out_row_end <= res_valid && result.tag.row_end;
      out_last    <= res_valid && result.tag.last;
    end
  end

  // Data
  always_ff @(posedge CLK) begin
    if (res_valid) begin
      out_data <= final_q;
    end
  end

  // Last element closes the stream for at least one cycle
  a_last_closes : assert property (@(posedge CLK) disable iff (RST)
    out_last |=> !out_valid);

endmodule

// File: rtl/matrix_fixed_divider.sv
/*
  Top level of the matrix element-wise Q16.16 divider. A and B stream in
  row-major order and quotients stream out in the same order, each with
  row-end and last flags. Start/busy frame one matrix operation.
*/

`timescale 1ns/10ps

module matrix_fixed_divider
  import matrix_divider_pkg::*;
(
  input  logic              CLK,
  input  logic              RST,

  // Control
  input  logic              start,
  input  logic [SIZE_W-1:0] size_i,
  input  logic [SIZE_W-1:0] size_j,
  output logic              busy,

  // Operand streams
  input  logic              a_valid,
  input  logic [DATA_W-1:0] a_data,
  output logic              a_ready,
  input  logic              b_valid,
  input  logic [DATA_W-1:0] b_data,
  output logic              b_ready,

  // Result stream
  output logic              out_valid,
  output logic [DATA_W-1:0] out_data,
  output logic              out_row_end,
  output logic              out_last
);

  ////////////////////////////////////////////////////////////////////////////
  // Internal wiring
  ////////////////////////////////////////////////////////////////////////////

  logic          accept_en;
  elem_tag_t     tag;
  logic          issue;
  div_operands_t operands;
  logic          div_busy;
  logic          res_valid;
  div_result_t   result;

  // Element position and busy window
  matrix_index_sequencer u_sequencer (
    .CLK      (CLK),
    .RST      (RST),
    .start    (start),
    .size_i   (size_i),
    .size_j   (size_j),
    .issue    (issue),
    .out_last (out_last),
    .accept_en(accept_en),
    .tag      (tag),
    .busy     (busy)
  );

  // A/B pairing
  operand_capture u_capture (
    .CLK      (CLK),
    .RST      (RST),
    .accept_en(accept_en),
    .tag      (tag),
    .a_valid  (a_valid),
    .a_data   (a_data),
    .a_ready  (a_ready),
    .b_valid  (b_valid),
    .b_data   (b_data),
    .b_ready  (b_ready),
    .div_busy (div_busy),
    .issue    (issue),
    .operands (operands)
  );

  // Restoring divider
  fixed_divider u_divider (
    .CLK      (CLK),
    .RST      (RST),
    .issue    (issue),
    .operands (operands),
    .div_busy (div_busy),
    .res_valid(res_valid),
    .result   (result)
  );

  // Saturation and output register
  division_result_stage u_result (
    .CLK        (CLK),
    .RST        (RST),
    .res_valid  (res_valid),
    .result     (result),
    .out_valid  (out_valid),
    .out_data   (out_data),
    .out_row_end(out_row_end),
    .out_last   (out_last)
  );

endmodule

// File: dv/tb_matrix_fixed_divider.sv
/*
  Table-driven testbench for the matrix Q16.16 divider. Each table entry
  streams one matrix through the DUT, optionally with random gaps and one
  operand stream lagging, and checks every quotient and flag in order.
*/

`timescale 1ns/10ps

module tb_matrix_fixed_divider
  import matrix_divider_pkg::*;
();

  // A, B and the hand-computed quotient
  typedef struct packed {
    logic [DATA_W-1:0] a;
    logic [DATA_W-1:0] b;
    logic [DATA_W-1:0] quo;
  } elem_vec_t;

  // One matrix run
  typedef struct packed {
    logic [SIZE_W-1:0] size_i;
    logic [SIZE_W-1:0] size_j;
    logic [7:0]        base;
    logic [3:0]        gap_max;
    logic [1:0]        lead;
  } test_vec_t;

  localparam int NUM_TESTS  = 6;
  localparam int NUM_ELEMS  = 23;
  localparam int LAG_CYCLES = 4;

  localparam logic [1:0] LEAD_NONE = 2'd0;
  localparam logic [1:0] LEAD_A    = 2'd1;
  localparam logic [1:0] LEAD_B    = 2'd2;

  logic              CLK;
  logic              RST;
  logic              start;
  logic [SIZE_W-1:0] size_i;
  logic [SIZE_W-1:0] size_j;
  logic              busy;
  logic              a_valid;
  logic [DATA_W-1:0] a_data;
  logic              a_ready;
  logic              b_valid;
  logic [DATA_W-1:0] b_data;
  logic              b_ready;
  logic              out_valid;
  logic [DATA_W-1:0] out_data;
  logic              out_row_end;
  logic              out_last;

  elem_vec_t elems [NUM_ELEMS];
  test_vec_t tests [NUM_TESTS];
  string     names [NUM_TESTS];

  int cycles = 0;
  int cycle_limit = 0;
  int err_count = 0;
  int test_errs = 0;
  int pass_count = 0;
  int fail_count = 0;

  matrix_fixed_divider u_matrix_fixed_divider (
    .CLK(CLK), .RST(RST), .start(start), .size_i(size_i), .size_j(size_j),
    .busy(busy), .a_valid(a_valid), .a_data(a_data), .a_ready(a_ready),
    .b_valid(b_valid), .b_data(b_data), .b_ready(b_ready),
    .out_valid(out_valid), .out_data(out_data),
    .out_row_end(out_row_end), .out_last(out_last)
  );

  initial begin
    CLK = 1'b0;
    forever #2 CLK = ~CLK;
  end

  // Run limit
  always @(posedge CLK) begin
    cycles <= cycles + 1;
    if (cycle_limit > 0 && cycles >= cycle_limit) begin
      $display("Timeout after %0d cycles, the DUT stopped delivering results", cycles);
      $display("Finished with errors");
      $finish;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus table
  ////////////////////////////////////////////////////////////////////////////

  task automatic load_table();
    // 3x4 mixed signs and fractions
    elems[0]  = '{32'h0006_0000, 32'h0002_0000, 32'h0003_0000};  // 6/2
    elems[1]  = '{32'h0001_0000, 32'h0004_0000, 32'h0000_4000};  // 1/4
    elems[2]  = '{32'hfffa_0000, 32'h0002_0000, 32'hfffd_0000};  // -6/2
    elems[3]  = '{32'h0007_8000, 32'hfffd_8000, 32'hfffd_0000};  // 7.5/-2.5
    elems[4]  = '{32'h0001_0000, 32'h0003_0000, 32'h0000_5555};  // 1/3 truncated
    elems[5]  = '{32'hffff_0000, 32'h0003_0000, 32'hffff_aaab};  // toward zero
    elems[6]  = '{32'hfff6_0000, 32'hfffc_0000, 32'h0002_8000};  // -10/-4
    elems[7]  = '{32'h0000_0000, 32'h0005_0000, 32'h0000_0000};
    elems[8]  = '{32'h0064_0000, 32'h0000_8000, 32'h00c8_0000};  // 100/0.5
    elems[9]  = '{32'h0000_c000, 32'h0001_8000, 32'h0000_8000};  // 0.75/1.5
    elems[10] = '{32'h0002_0000, 32'h0007_0000, 32'h0000_4924};  // 2/7
    elems[11] = '{32'hfffe_0000, 32'h0007_0000, 32'hffff_b6dc};
    // 1x1
    elems[12] = '{32'h0001_0000, 32'hfff8_0000, 32'hffff_e000};  // 1/-8
    // 4x1 column
    elems[13] = '{32'h0005_0000, 32'h0002_0000, 32'h0002_8000};
    elems[14] = '{32'hfffb_0000, 32'h0002_0000, 32'hfffd_8000};
    elems[15] = '{32'h0000_8000, 32'h0000_4000, 32'h0002_0000};
    elems[16] = '{32'h0000_0001, 32'h0001_0000, 32'h0000_0001};  // smallest step
    // Divide by zero and out of range
    elems[17] = '{32'h0001_0000, 32'h0000_0000, 32'h7fff_ffff};
    elems[18] = '{32'hffff_0000, 32'h0000_0000, 32'h8000_0000};
    elems[19] = '{32'h0000_0000, 32'h0000_0000, 32'h7fff_ffff};  // 0/0
    elems[20] = '{32'h7fff_0000, 32'h0000_8000, 32'h7fff_ffff};
    elems[21] = '{32'h7fff_0000, 32'hffff_8000, 32'h8000_0000};
    elems[22] = '{32'h8000_0000, 32'hffff_0000, 32'h7fff_ffff};  // +32768

    tests[0] = '{8'd3, 8'd4, 8'd0,  4'd0, LEAD_NONE};
    tests[1] = '{8'd1, 8'd1, 8'd12, 4'd0, LEAD_NONE};
    tests[2] = '{8'd4, 8'd1, 8'd13, 4'd0, LEAD_NONE};
    tests[3] = '{8'd2, 8'd3, 8'd17, 4'd0, LEAD_NONE};
    // Same 3x4 data again under random gaps
    tests[4] = '{8'd3, 8'd4, 8'd0,  4'd3, LEAD_A};
    tests[5] = '{8'd3, 8'd4, 8'd0,  4'd3, LEAD_B};

    names[0] = "mixed_3x4";
    names[1] = "single_1x1";
    names[2] = "column_4x1";
    names[3] = "saturate_2x3";
    names[4] = "gaps_a_leads_3x4";
    names[5] = "gaps_b_leads_3x4";
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Drivers and monitor
  ////////////////////////////////////////////////////////////////////////////

  // One operand stream; valid and data held until the transfer
  task automatic drive_stream(input string name, input bit is_b, input int base,
                              input int n, input int gap_max, input bit lagging);
    int k;
    int gap;
    logic rdy;
    for (k = 0; k < n; k++) begin
      gap = $urandom % (gap_max + 1);
      if (lagging) begin
        gap = gap + LAG_CYCLES;
      end
      repeat (gap) begin
        @(posedge CLK);
        #1;
      end
      if (is_b) begin
        b_valid = 1'b1;
        b_data  = elems[base + k].b;
      end else begin
        a_valid = 1'b1;
        a_data  = elems[base + k].a;
      end
      // Ready is stable between edges
      while (!(is_b ? b_ready : a_ready)) begin
        @(posedge CLK);
        #1;
      end
      @(posedge CLK);
      #1;
      // Slot just filled, so ready stays low until the pair issues
      rdy = is_b ? b_ready : a_ready;
      if (rdy !== 1'b0) begin
        $display("** Error %s: %s ready after transfer expected 0 actual %b",
                 name, is_b ? "b" : "a", rdy);
        test_errs++;
      end
      if (is_b) begin
        b_valid = 1'b0;
      end else begin
        a_valid = 1'b0;
      end
    end
  endtask

  // Second start in the middle of a run, must be ignored
  task automatic restart_while_busy();
    repeat (3) begin
      @(posedge CLK);
      #1;
    end
    start  = 1'b1;
    size_i = 8'd2;
    size_j = 8'd2;
    @(posedge CLK);
    #1;
    start = 1'b0;
  endtask

  task automatic check_outputs(input int t);
    int k;
    int n;
    int sj;
    logic [DATA_W-1:0] exp_q;
    logic exp_row_end;
    logic exp_last;
    sj = int'(tests[t].size_j);
    n  = int'(tests[t].size_i) * sj;
    k  = 0;
    while (k < n) begin
      @(negedge CLK);
      if (out_valid) begin
        exp_q       = elems[int'(tests[t].base) + k].quo;
        exp_row_end = (k % sj) == (sj - 1);
        exp_last    = (k == n - 1);
        if (out_data !== exp_q) begin
          $display("** Error %s: element %0d data expected %h actual %h",
                   names[t], k, exp_q, out_data);
          test_errs++;
        end
        if (out_row_end !== exp_row_end) begin
          $display("** Error %s: element %0d row_end expected %b actual %b",
                   names[t], k, exp_row_end, out_row_end);
          test_errs++;
        end
        if (out_last !== exp_last) begin
          $display("** Error %s: element %0d last expected %b actual %b",
                   names[t], k, exp_last, out_last);
          test_errs++;
        end
        k++;
      end
    end
    // busy falls one cycle after out_last
    @(negedge CLK);
    if (busy !== 1'b0) begin
      $display("** Error %s: busy after last expected 0 actual %b", names[t], busy);
      test_errs++;
    end
    repeat (8) begin
      @(negedge CLK);
      if (out_valid) begin
        $display("%s: an extra output appeared after the last element", names[t]);
        test_errs++;
      end
    end
  endtask

  task automatic run_test(input int t);
    test_vec_t tv;
    int n;
    tv = tests[t];
    n  = int'(tv.size_i) * int'(tv.size_j);
    test_errs = 0;
    // Line up with the drive point after a rising edge
    @(posedge CLK);
    #1;
    start  = 1'b1;
    size_i = tv.size_i;
    size_j = tv.size_j;
    @(posedge CLK);
    #1;
    start = 1'b0;
    if (busy !== 1'b1) begin
      $display("** Error %s: busy after start expected 1 actual %b", names[t], busy);
      test_errs++;
    end
    fork
      drive_stream(names[t], 1'b0, int'(tv.base), n, int'(tv.gap_max),
                   tv.lead == LEAD_B);
      drive_stream(names[t], 1'b1, int'(tv.base), n, int'(tv.gap_max),
                   tv.lead == LEAD_A);
      check_outputs(t);
      restart_while_busy();
    join
    if (test_errs == 0) begin
      $display("PASS %s", names[t]);
      pass_count++;
    end else begin
      $display("FAIL %s with %0d errors", names[t], test_errs);
      fail_count++;
    end
    err_count += test_errs;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    int t;
    int total;
    RST     = 1'b1;
    start   = 1'b0;
    size_i  = '0;
    size_j  = '0;
    a_valid = 1'b0;
    a_data  = '0;
    b_valid = 1'b0;
    b_data  = '0;
    void'($urandom(32'ha6da_de08));
    load_table();

    // 60 cycles per element plus setup margin
    total = 0;
    for (t = 0; t < NUM_TESTS; t++) begin
      total += int'(tests[t].size_i) * int'(tests[t].size_j);
    end
    cycle_limit = total * 60 + 200;

    repeat (10) @(posedge CLK);
    #1;
    RST = 1'b0;
    // Order is busy, out_valid, a_ready, b_ready
    if ({busy, out_valid, a_ready, b_ready} !== 4'b0000) begin
      $display("** Error reset: status expected 0000 actual %b%b%b%b",
               busy, out_valid, a_ready, b_ready);
      err_count++;
    end

    for (t = 0; t < NUM_TESTS; t++) begin
      run_test(t);
    end

    $display("Tests: %0d passed, %0d failed, %0d errors", pass_count, fail_count, err_count);
    if (err_count == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

// File: sources.f
rtl/matrix_divider_pkg.sv
rtl/matrix_index_sequencer.sv
rtl/operand_capture.sv
rtl/fixed_divider.sv
rtl/division_result_stage.sv
rtl/matrix_fixed_divider.sv
dv/tb_matrix_fixed_divider.sv

// File: run.sh
#!/bin/sh
# Build the matrix divider testbench with Verilator and run it.
# The exit status is non-zero unless the run prints the pass line.
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f sources.f \
  --top-module tb_matrix_fixed_divider -Mdir obj_dir -o sim_tb &&
./obj_dir/sim_tb | tee /dev/stderr | grep -x "Finished with no errors" > /dev/null &&
echo "Simulation passed" ||
{ echo "Simulation failed"; exit 1; }
